// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_bus_subsystem
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
src/bus_pkg.sv
src/bus_sender.sv
src/bus_arbiter.sv
src/bus_receiver.sv
src/bus_subsystem.sv
verification/tb_bus_subsystem.sv

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter #(
    parameter int NUM_SENDERS = 2
) (
    input  logic                                   clk_bus,
    input  logic                                   reset,
    input  logic [NUM_SENDERS-1:0]                 req,
    input  logic [NUM_SENDERS-1:0]                 releases,
    input  logic [NUM_SENDERS-1:0]                 bus_drive,
    input  bus_pkg::bus_word_t [NUM_SENDERS-1:0]   bus_in,
    output logic [NUM_SENDERS-1:0]                 ack,
    output logic [NUM_SENDERS-1:0]                 grant,
    output bus_pkg::bus_word_t                     bus_word
);

    localparam int IDX_W = (NUM_SENDERS > 1) ? $clog2(NUM_SENDERS) : 1;

    bus_pkg::arb_state_t state;
    logic [IDX_W-1:0]    owner;
    logic [IDX_W-1:0]    pick;
    logic                any_req;

    ////////////////////////////////////////
    // round robin pick
    ////////////////////////////////////////
    // scan from the farthest slot inward so the one just after owner wins
    always_comb begin
        int idx;
        pick    = owner;
        any_req = 1'b0;
        for (int i = NUM_SENDERS; i >= 1; i--) begin
            idx = (int'(owner) + i) % NUM_SENDERS;
            if (req[idx]) begin
                pick    = IDX_W'(idx);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (reset) begin
            state <= bus_pkg::IDLE;
            owner <= IDX_W'(NUM_SENDERS - 1);
            ack   <= '0;
            grant <= '0;
        end else begin
            ack <= '0;
            case (state)
                bus_pkg::IDLE: begin
                    if (any_req) begin
                        ack   <= NUM_SENDERS'(1) << pick;
                        owner <= pick;
                        state <= bus_pkg::ACKED;
                    end
                end
                bus_pkg::ACKED: begin
                    grant <= NUM_SENDERS'(1) << owner;
                    state <= bus_pkg::GRANTED;
                end
                bus_pkg::GRANTED: begin
                    // owner kept as last winner for the next pick
                    if (releases[owner]) begin
                        grant <= '0;
                        state <= bus_pkg::IDLE;
                    end
                end
                default: state <= bus_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // bus multiplexer
    ////////////////////////////////////////
    always_comb begin
        bus_word = '0;
        for (int i = 0; i < NUM_SENDERS; i++) begin
            if (grant[i] && bus_drive[i]) bus_word = bus_word | bus_in[i];
        end
    end

    a_grant_onehot: assert property (@(posedge clk_bus) disable iff (reset)
        $onehot0(grant));

    a_ack_to_requester: assert property (@(posedge clk_bus) disable iff (reset)
        (ack & ~req) == '0);

    a_drive_granted: assert property (@(posedge clk_bus) disable iff (reset)
        (bus_drive & ~grant) == '0);

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int BUS_W      = 73;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;

    typedef logic [14:0]               paddr_t;
    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
    typedef logic [3:0]                node_id_t;
    typedef logic [LINE_WORDS-1:0]     beat_mask_t;
    typedef logic [BUS_W-1:0]          bus_word_t;

    // bus word field positions, bits 72:61 stay zero
    localparam int VALID_BIT = 0;
    localparam int ADDR_LSB  = 1;
    localparam int ADDR_MSB  = 15;
    localparam int DATA_LSB  = 16;
    localparam int DATA_MSB  = 47;
    localparam int RET_LSB   = 48;
    localparam int RET_MSB   = 51;
    localparam int DEST_LSB  = 52;
    localparam int DEST_MSB  = 55;
    localparam int RW_BIT    = 56;
    localparam int MASK_LSB  = 57;
    localparam int MASK_MSB  = 60;

    typedef enum logic [1:0] {
        FREE,
        REQUEST,
        WAIT_GRANT,
        DRIVE
    } sender_state_t;

    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        GRANTED
    } arb_state_t;

endpackage

`default_nettype wire

// ==== src/bus_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_receiver #(
    parameter bus_pkg::node_id_t NODE_ID = 4'd1
) (
    input  logic                 clk_bus,
    input  logic                 reset,
    input  bus_pkg::bus_word_t   bus_word,
    output logic                 done,
    output bus_pkg::line_t       line_out,
    output bus_pkg::paddr_t      paddr_out,
    output bus_pkg::node_id_t    return_out,
    output logic                 rw_out
);

    bus_pkg::beat_mask_t beat_mask;
    bus_pkg::word_t      beat_data;
    bus_pkg::line_t      asm_q;
    bus_pkg::line_t      asm_next;
    logic                hit;
    logic                last;

    assign beat_mask = bus_word[bus_pkg::MASK_MSB:bus_pkg::MASK_LSB];
    assign beat_data = bus_word[bus_pkg::DATA_MSB:bus_pkg::DATA_LSB];
    assign hit  = bus_word[bus_pkg::VALID_BIT]
               && (bus_word[bus_pkg::DEST_MSB:bus_pkg::DEST_LSB] == NODE_ID);
    assign last = hit && beat_mask[0];

    ////////////////////////////////////////
    // line assembly
    ////////////////////////////////////////
    // drop the beat into the slot its pointer names
    always_comb begin
        asm_next = asm_q;
        for (int i = 0; i < bus_pkg::LINE_WORDS; i++) begin
            if (beat_mask[i]) asm_next[i*bus_pkg::WORD_W +: bus_pkg::WORD_W] = beat_data;
        end
    end

    // buffer cleared after each line so unsent words read zero
    always_ff @(posedge clk_bus) begin
        if (reset) begin
            asm_q <= '0;
            done  <= 1'b0;
        end else begin
            done <= last;
            if (last) begin
                asm_q <= '0;
            end else if (hit) begin
                asm_q <= asm_next;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (last) begin
            line_out <= asm_next;
        end
        if (hit) begin
            paddr_out  <= bus_word[bus_pkg::ADDR_MSB:bus_pkg::ADDR_LSB];
            return_out <= bus_word[bus_pkg::RET_MSB:bus_pkg::RET_LSB];
            rw_out     <= bus_word[bus_pkg::RW_BIT];
        end
    end

    // pointer comes from a sender on the far side of the arbiter
    a_beat_onehot: assert property (@(posedge clk_bus) disable iff (reset)
        hit |-> $onehot(beat_mask));

endmodule

`default_nettype wire

// ==== src/bus_sender.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_sender (
    input  logic                  clk_bus,
    input  logic                  reset,

    // from block
    input  logic                  valid_in,
    input  bus_pkg::paddr_t       paddr_in,
    input  bus_pkg::line_t        data_in,
    input  bus_pkg::node_id_t     dest_in,
    input  bus_pkg::node_id_t     return_in,
    input  logic                  rw_in,
    input  bus_pkg::beat_mask_t   size_in,
    output logic                  free,

    // arbiter handshake
    input  logic                  ack,
    input  logic                  grant,
    output logic                  req,
    output logic                  releases,

    // bus side
    output logic                  bus_drive,
    output bus_pkg::bus_word_t    bus_out
);

    bus_pkg::sender_state_t state, state_next;

    bus_pkg::paddr_t     paddr_q;
    bus_pkg::line_t      line_q;
    bus_pkg::node_id_t   dest_q;
    bus_pkg::node_id_t   return_q;
    logic                rw_q;
    bus_pkg::beat_mask_t mask_q;
    bus_pkg::word_t      beat_data;
    logic                accept;

    assign free      = (state == bus_pkg::FREE);
    assign req       = (state == bus_pkg::REQUEST);
    assign bus_drive = (state == bus_pkg::DRIVE);
    assign accept    = valid_in && free;
    // last beat is the one with bit 0 of the pointer set
    assign releases  = bus_drive && mask_q[0];

    ////////////////////////////////////////
    // handshake FSM
    ////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            bus_pkg::FREE:       if (accept) state_next = bus_pkg::REQUEST;
            bus_pkg::REQUEST:    if (ack) state_next = bus_pkg::WAIT_GRANT;
            bus_pkg::WAIT_GRANT: if (grant) state_next = bus_pkg::DRIVE;
            bus_pkg::DRIVE:      if (mask_q[0]) state_next = bus_pkg::FREE;
            default:             state_next = bus_pkg::FREE;
        endcase
    end

    always_ff @(posedge clk_bus) begin
        if (reset) begin
            state <= bus_pkg::FREE;
        end else begin
            state <= state_next;
        end
    end

    // payload capture and the mask walking down one word per beat
    always_ff @(posedge clk_bus) begin
        if (accept) begin
            paddr_q  <= paddr_in;
            line_q   <= data_in;
            dest_q   <= dest_in;
            return_q <= return_in;
            rw_q     <= rw_in;
            mask_q   <= size_in;
        end else if (bus_drive) begin
            mask_q <= mask_q >> 1;
        end
    end

    ////////////////////////////////////////
    // beat assembly
    ////////////////////////////////////////
    always_comb begin
        beat_data = '0;
        for (int i = 0; i < bus_pkg::LINE_WORDS; i++) begin
            if (mask_q[i]) beat_data = line_q[i*bus_pkg::WORD_W +: bus_pkg::WORD_W];
        end
    end

    always_comb begin
        bus_out = '0;
        bus_out[bus_pkg::VALID_BIT]                   = bus_drive;
        bus_out[bus_pkg::ADDR_MSB:bus_pkg::ADDR_LSB] = paddr_q;
        bus_out[bus_pkg::DATA_MSB:bus_pkg::DATA_LSB] = beat_data;
        bus_out[bus_pkg::RET_MSB:bus_pkg::RET_LSB]   = return_q;
        bus_out[bus_pkg::DEST_MSB:bus_pkg::DEST_LSB] = dest_q;
        bus_out[bus_pkg::RW_BIT]                      = rw_q;
        bus_out[bus_pkg::MASK_MSB:bus_pkg::MASK_LSB] = mask_q;
    end

    // grant has to stay up for every beat
    a_drive_with_grant: assert property (@(posedge clk_bus) disable iff (reset)
        bus_drive |-> grant);

    a_mask_onehot: assert property (@(posedge clk_bus) disable iff (reset)
        accept |=> $onehot(mask_q));

    // arbiter takes the bus back right after the last beat
    a_release_last: assert property (@(posedge clk_bus) disable iff (reset)
        releases |=> !grant);

endmodule

`default_nettype wire

// ==== src/bus_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_subsystem #(
    parameter int                NUM_SENDERS = 2,
    parameter bus_pkg::node_id_t RX_A_ID     = 4'd1,
    parameter bus_pkg::node_id_t RX_B_ID     = 4'd2
) (
    input  logic                 clk_bus,
    input  logic                 reset,

    input  logic                 s0_valid_in,
    input  bus_pkg::paddr_t      s0_paddr_in,
    input  bus_pkg::line_t       s0_data_in,
    input  bus_pkg::node_id_t    s0_dest_in,
    input  bus_pkg::node_id_t    s0_return_in,
    input  logic                 s0_rw_in,
    input  bus_pkg::beat_mask_t  s0_size_in,

    input  logic                 s1_valid_in,
    input  bus_pkg::paddr_t      s1_paddr_in,
    input  bus_pkg::line_t       s1_data_in,
    input  bus_pkg::node_id_t    s1_dest_in,
    input  bus_pkg::node_id_t    s1_return_in,
    input  logic                 s1_rw_in,
    input  bus_pkg::beat_mask_t  s1_size_in,

    output logic                 s0_free,
    output logic                 s1_free,
    output bus_pkg::bus_word_t   bus_word,

    output logic                 ra_done,
    output bus_pkg::line_t       ra_line_out,
    output bus_pkg::paddr_t      ra_paddr_out,
    output bus_pkg::node_id_t    ra_return_out,
    output logic                 ra_rw_out,

    output logic                 rb_done,
    output bus_pkg::line_t       rb_line_out,
    output bus_pkg::paddr_t      rb_paddr_out,
    output bus_pkg::node_id_t    rb_return_out,
    output logic                 rb_rw_out
);

    logic [NUM_SENDERS-1:0]               req;
    logic [NUM_SENDERS-1:0]               ack;
    logic [NUM_SENDERS-1:0]               grant;
    logic [NUM_SENDERS-1:0]               releases;
    logic [NUM_SENDERS-1:0]               bus_drive;
    bus_pkg::bus_word_t [NUM_SENDERS-1:0] bus_out;

    ////////////////////////////////////////
    // senders
    ////////////////////////////////////////
    bus_sender u_sender0 (
        .clk_bus   (clk_bus),
        .reset     (reset),
        .valid_in  (s0_valid_in),
        .paddr_in  (s0_paddr_in),
        .data_in   (s0_data_in),
        .dest_in   (s0_dest_in),
        .return_in (s0_return_in),
        .rw_in     (s0_rw_in),
        .size_in   (s0_size_in),
        .free      (s0_free),
        .ack       (ack[0]),
        .grant     (grant[0]),
        .req       (req[0]),
        .releases  (releases[0]),
        .bus_drive (bus_drive[0]),
        .bus_out   (bus_out[0])
    );

    bus_sender u_sender1 (
        .clk_bus   (clk_bus),
        .reset     (reset),
        .valid_in  (s1_valid_in),
        .paddr_in  (s1_paddr_in),
        .data_in   (s1_data_in),
        .dest_in   (s1_dest_in),
        .return_in (s1_return_in),
        .rw_in     (s1_rw_in),
        .size_in   (s1_size_in),
        .free      (s1_free),
        .ack       (ack[1]),
        .grant     (grant[1]),
        .req       (req[1]),
        .releases  (releases[1]),
        .bus_drive (bus_drive[1]),
        .bus_out   (bus_out[1])
    );

    ////////////////////////////////////////
    // arbiter and bus
    ////////////////////////////////////////
    bus_arbiter #(
        .NUM_SENDERS (NUM_SENDERS)
    ) u_arbiter (
        .clk_bus   (clk_bus),
        .reset     (reset),
        .req       (req),
        .releases  (releases),
        .bus_drive (bus_drive),
        .bus_in    (bus_out),
        .ack       (ack),
        .grant     (grant),
        .bus_word  (bus_word)
    );

    ////////////////////////////////////////
    // receivers
    ////////////////////////////////////////
    bus_receiver #(
        .NODE_ID (RX_A_ID)
    ) u_receiver_a (
        .clk_bus    (clk_bus),
        .reset      (reset),
        .bus_word   (bus_word),
        .done       (ra_done),
        .line_out   (ra_line_out),
        .paddr_out  (ra_paddr_out),
        .return_out (ra_return_out),
        .rw_out     (ra_rw_out)
    );

    bus_receiver #(
        .NODE_ID (RX_B_ID)
    ) u_receiver_b (
        .clk_bus    (clk_bus),
        .reset      (reset),
        .bus_word   (bus_word),
        .done       (rb_done),
        .line_out   (rb_line_out),
        .paddr_out  (rb_paddr_out),
        .return_out (rb_return_out),
        .rw_out     (rb_rw_out)
    );

endmodule

`default_nettype wire

// ==== verification/tb_bus_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bus_subsystem;

    localparam time CLK_PERIOD      = 10;
    localparam int  NUM_TESTS       = 6;
    localparam int  CYCLES_PER_TEST = 300;
    localparam time WATCHDOG        = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
    localparam int  WAIT_LIMIT      = 200;

    logic clk_bus;
    logic reset;

    logic                s0_valid_in, s1_valid_in;
    bus_pkg::paddr_t     s0_paddr_in, s1_paddr_in;
    bus_pkg::line_t      s0_data_in, s1_data_in;
    bus_pkg::node_id_t   s0_dest_in, s1_dest_in;
    bus_pkg::node_id_t   s0_return_in, s1_return_in;
    logic                s0_rw_in, s1_rw_in;
    bus_pkg::beat_mask_t s0_size_in, s1_size_in;

    logic                s0_free, s1_free;
    bus_pkg::bus_word_t  bus_word;
    logic                ra_done, rb_done;
    bus_pkg::line_t      ra_line_out, rb_line_out;
    bus_pkg::paddr_t     ra_paddr_out, rb_paddr_out;
    bus_pkg::node_id_t   ra_return_out, rb_return_out;
    logic                ra_rw_out, rb_rw_out;

    // scoreboard, one expected line per receiver
    logic              expect_a, expect_b, quiet;
    bus_pkg::line_t    exp_line_a, exp_line_b;
    bus_pkg::paddr_t   exp_paddr_a, exp_paddr_b;
    bus_pkg::node_id_t exp_ret_a, exp_ret_b;
    logic              exp_rw_a, exp_rw_b;

    int seed = 22053;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    bus_subsystem #(
        .NUM_SENDERS (2),
        .RX_A_ID     (4'd1),
        .RX_B_ID     (4'd2)
    ) dut (
        .clk_bus (clk_bus), .reset (reset),
        .s0_valid_in (s0_valid_in), .s0_paddr_in (s0_paddr_in), .s0_data_in (s0_data_in),
        .s0_dest_in (s0_dest_in), .s0_return_in (s0_return_in), .s0_rw_in (s0_rw_in),
        .s0_size_in (s0_size_in),
        .s1_valid_in (s1_valid_in), .s1_paddr_in (s1_paddr_in), .s1_data_in (s1_data_in),
        .s1_dest_in (s1_dest_in), .s1_return_in (s1_return_in), .s1_rw_in (s1_rw_in),
        .s1_size_in (s1_size_in),
        .s0_free (s0_free), .s1_free (s1_free), .bus_word (bus_word),
        .ra_done (ra_done), .ra_line_out (ra_line_out), .ra_paddr_out (ra_paddr_out),
        .ra_return_out (ra_return_out), .ra_rw_out (ra_rw_out),
        .rb_done (rb_done), .rb_line_out (rb_line_out), .rb_paddr_out (rb_paddr_out),
        .rb_return_out (rb_return_out), .rb_rw_out (rb_rw_out)
    );

    initial begin
        clk_bus = 1'b0;
        forever #(CLK_PERIOD / 2) clk_bus = ~clk_bus;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired at %0t, tests did not finish", $time);
        $display("Result: FAILED");
        $finish;
    end

    // words above the highest pointer bit are never sent
    function automatic bus_pkg::line_t expected_line(input bus_pkg::line_t d,
                                                     input bus_pkg::beat_mask_t m);
        bus_pkg::line_t r;
        logic           keep;
        r    = '0;
        keep = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (m[i]) keep = 1'b1;
            if (keep) r[i*32 +: 32] = d[i*32 +: 32];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
        errors++;
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    a_idle: assert property (@(posedge clk_bus) disable iff (reset)
        quiet |-> s0_free && s1_free && !bus_word[bus_pkg::VALID_BIT])
        else begin
            $display("bus not idle after reset at %0t", $time);
            errors++;
        end

    // a transfer keeps its destination from first beat to last
    a_no_interleave: assert property (@(posedge clk_bus) disable iff (reset)
        (bus_word[bus_pkg::VALID_BIT] && !bus_word[bus_pkg::MASK_LSB]) |=>
        (bus_word[bus_pkg::VALID_BIT] && bus_word[bus_pkg::DEST_MSB:bus_pkg::DEST_LSB]
            == $past(bus_word[bus_pkg::DEST_MSB:bus_pkg::DEST_LSB])))
        else begin
            $display("bus beats of two transfers interleaved at %0t", $time);
            errors++;
        end

    a_done_a: assert property (@(posedge clk_bus) disable iff (reset) ra_done |-> expect_a)
        else begin
            $display("unexpected done pulse on receiver A at %0t", $time);
            errors++;
        end
    a_line_a: assert property (@(posedge clk_bus) disable iff (reset)
        ra_done && expect_a |-> ra_line_out == exp_line_a)
        else report_mismatch("ra_line_out", $sampled(exp_line_a), $sampled(ra_line_out));
    a_paddr_a: assert property (@(posedge clk_bus) disable iff (reset)
        ra_done && expect_a |-> ra_paddr_out == exp_paddr_a)
        else report_mismatch("ra_paddr_out", 128'($sampled(exp_paddr_a)),
                             128'($sampled(ra_paddr_out)));
    a_ret_a: assert property (@(posedge clk_bus) disable iff (reset)
        ra_done && expect_a |-> ra_return_out == exp_ret_a)
        else report_mismatch("ra_return_out", 128'($sampled(exp_ret_a)),
                             128'($sampled(ra_return_out)));
    a_rw_a: assert property (@(posedge clk_bus) disable iff (reset)
        ra_done && expect_a |-> ra_rw_out == exp_rw_a)
        else report_mismatch("ra_rw_out", 128'($sampled(exp_rw_a)), 128'($sampled(ra_rw_out)));

    a_done_b: assert property (@(posedge clk_bus) disable iff (reset) rb_done |-> expect_b)
        else begin
            $display("unexpected done pulse on receiver B at %0t", $time);
            errors++;
        end
    a_line_b: assert property (@(posedge clk_bus) disable iff (reset)
        rb_done && expect_b |-> rb_line_out == exp_line_b)
        else report_mismatch("rb_line_out", $sampled(exp_line_b), $sampled(rb_line_out));
    a_paddr_b: assert property (@(posedge clk_bus) disable iff (reset)
        rb_done && expect_b |-> rb_paddr_out == exp_paddr_b)
        else report_mismatch("rb_paddr_out", 128'($sampled(exp_paddr_b)),
                             128'($sampled(rb_paddr_out)));
    a_ret_b: assert property (@(posedge clk_bus) disable iff (reset)
        rb_done && expect_b |-> rb_return_out == exp_ret_b)
        else report_mismatch("rb_return_out", 128'($sampled(exp_ret_b)),
                             128'($sampled(rb_return_out)));
    a_rw_b: assert property (@(posedge clk_bus) disable iff (reset)
        rb_done && expect_b |-> rb_rw_out == exp_rw_b)
        else report_mismatch("rb_rw_out", 128'($sampled(exp_rw_b)), 128'($sampled(rb_rw_out)));

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////
    // random payload onto one sender, scoreboard armed only when asked
    task automatic issue(input int s, input bus_pkg::node_id_t dst,
                         input bus_pkg::beat_mask_t m, input logic arm);
        logic [31:0]       r0, r1, r2, r3, r4;
        bus_pkg::line_t    d;
        bus_pkg::paddr_t   a;
        bus_pkg::node_id_t ret;
        logic              rw;
        r0  = $random(seed);
        r1  = $random(seed);
        r2  = $random(seed);
        r3  = $random(seed);
        r4  = $random(seed);
        d   = {r3, r2, r1, r0};
        a   = r4[14:0];
        ret = r4[19:16];
        rw  = r4[24];
        if (s == 0) begin
            s0_valid_in <= 1'b1;
            s0_paddr_in <= a;
            s0_data_in <= d;
            s0_dest_in <= dst;
            s0_return_in <= ret;
            s0_rw_in <= rw;
            s0_size_in <= m;
        end else begin
            s1_valid_in <= 1'b1;
            s1_paddr_in <= a;
            s1_data_in <= d;
            s1_dest_in <= dst;
            s1_return_in <= ret;
            s1_rw_in <= rw;
            s1_size_in <= m;
        end
        if (arm && dst == 4'd1) begin
            expect_a <= 1'b1;
            exp_line_a <= expected_line(d, m);
            exp_paddr_a <= a;
            exp_ret_a <= ret;
            exp_rw_a <= rw;
        end else if (arm && dst == 4'd2) begin
            expect_b <= 1'b1;
            exp_line_b <= expected_line(d, m);
            exp_paddr_b <= a;
            exp_ret_b <= ret;
            exp_rw_b <= rw;
        end
    endtask

    task automatic drop_valid();
        s0_valid_in <= 1'b0;
        s1_valid_in <= 1'b0;
    endtask

    task automatic wait_done(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n && cycles < WAIT_LIMIT) begin
            @(posedge clk_bus);
            cycles++;
            if (ra_done) begin
                seen++;
                expect_a <= 1'b0;
            end
            if (rb_done) begin
                seen++;
                expect_b <= 1'b0;
            end
        end
        if (seen < n) begin
            $display("timeout at %0t, only %0d of %0d lines delivered", $time, seen, n);
            errors++;
        end
    endtask

    // both senders back to free, then a quiet stretch for stray done pulses
    task automatic wait_free_settle();
        int cycles;
        cycles = 0;
        @(posedge clk_bus);
        while (!(s0_free && s1_free) && cycles < WAIT_LIMIT) begin
            @(posedge clk_bus);
            cycles++;
        end
        if (!(s0_free && s1_free)) begin
            $display("timeout at %0t, a sender never returned to free", $time);
            errors++;
        end
        repeat (20) @(posedge clk_bus);
    endtask

    task automatic close_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int mark;
        reset = 1'b1;
        quiet = 1'b0;
        expect_a = 1'b0;
        expect_b = 1'b0;
        exp_line_a = '0;
        exp_line_b = '0;
        exp_paddr_a = '0;
        exp_paddr_b = '0;
        exp_ret_a = '0;
        exp_ret_b = '0;
        exp_rw_a = 1'b0;
        exp_rw_b = 1'b0;
        s0_valid_in = 1'b0;
        s0_paddr_in = '0;
        s0_data_in = '0;
        s0_dest_in = '0;
        s0_return_in = '0;
        s0_rw_in = 1'b0;
        s0_size_in = '0;
        s1_valid_in = 1'b0;
        s1_paddr_in = '0;
        s1_data_in = '0;
        s1_dest_in = '0;
        s1_return_in = '0;
        s1_rw_in = 1'b0;
        s1_size_in = '0;
        repeat (4) @(posedge clk_bus);
        reset <= 1'b0;

        mark = errors;
        @(posedge clk_bus);
        quiet <= 1'b1;
        repeat (20) @(posedge clk_bus);
        quiet <= 1'b0;
        close_test(1, "idle after reset", mark);

        mark = errors;
        @(posedge clk_bus);
        issue(0, 4'd1, 4'b1000, 1'b1);
        @(posedge clk_bus);
        drop_valid();
        wait_done(1);
        wait_free_settle();
        close_test(2, "four-beat transfer", mark);

        mark = errors;
        @(posedge clk_bus);
        issue(1, 4'd2, 4'b0010, 1'b1);
        @(posedge clk_bus);
        drop_valid();
        wait_done(1);
        wait_free_settle();
        close_test(3, "partial transfer", mark);

        mark = errors;
        @(posedge clk_bus);
        issue(0, 4'd1, 4'b1000, 1'b1);
        issue(1, 4'd2, 4'b0100, 1'b1);
        @(posedge clk_bus);
        drop_valid();
        wait_done(2);
        wait_free_settle();
        close_test(4, "contention", mark);

        // second payload lands while the sender is busy
        mark = errors;
        @(posedge clk_bus);
        issue(0, 4'd2, 4'b0100, 1'b1);
        @(posedge clk_bus);
        issue(0, 4'd1, 4'b1000, 1'b0);
        @(posedge clk_bus);
        drop_valid();
        wait_done(1);
        wait_free_settle();
        close_test(5, "valid while busy", mark);

        mark = errors;
        @(posedge clk_bus);
        issue(0, 4'd5, 4'b1000, 1'b0);
        @(posedge clk_bus);
        drop_valid();
        wait_free_settle();
        issue(0, 4'd1, 4'b0001, 1'b1);
        @(posedge clk_bus);
        drop_valid();
        wait_done(1);
        wait_free_settle();
        close_test(6, "unmatched destination", mark);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
